//--- design/owt_rx_macros.svh
`ifndef OWT_RX_MACROS_SVH
`define OWT_RX_MACROS_SVH

// ==========================================================================
// frame field widths
// ==========================================================================
`define OWT_CMD_BITS   8
`define OWT_ADCD_BITS  12
`define OWT_DATA_BITS  8
`define OWT_CRC_BITS   8

// rising edges in the sync head
`define OWT_SYNC_BITS  12
// head bit count below which the symbol average still moves
`define OWT_AVG_LAST   10

// ==========================================================================
// counter widths
// ==========================================================================
`define OWT_CYC_W      10
`define OWT_BITCNT_W   4

// crc-8, init zero, msb first
`define OWT_CRC_POLY   8'h07
// read of this address carries adc data
`define OWT_ADC_ADDR   7'h1F

// leaky-bucket error counter
`define OWT_ERR_CNT_W  5
`define OWT_ERR_MAX    15
`define OWT_ERR_INIT   15

`endif

//--- design/owt_frame_pkg.sv
`default_nettype none

`include "owt_rx_macros.svh"

package owt_frame_pkg;

    // frame parts, in line order
    typedef enum logic [2:0] {
        IDLE,
        SYNC_HEAD,
        SYNC_TAIL,
        CMD,
        ADC_DATA,
        NML_DATA,
        CRC,
        END_TAIL
    } owt_state_e;

    // edge strobes, plus copies one cycle later
    typedef struct packed {
        logic rise;
        logic fall;
        logic rise_d;
        logic fall_d;
    } owt_edge_t;

    // length of a finished edge interval, in symbols
    typedef struct packed {
        logic vld;
        logic one;
        logic two;
        logic three;
    } owt_sym_t;

    typedef struct packed {
        logic vld;
        logic val;
        logic invld;
    } owt_bit_t;

    typedef struct packed {
        logic [`OWT_ADCD_BITS-`OWT_DATA_BITS-1:0] pad;
        logic [`OWT_DATA_BITS-1:0]                value;
    } owt_nml_t;

    // adc word or normal byte, picked by the command
    typedef union packed {
        logic [`OWT_ADCD_BITS-1:0] adc;
        owt_nml_t                  nml;
    } owt_data_u;

    typedef struct packed {
        logic [`OWT_CMD_BITS-1:0] cmd;
        owt_data_u                data;
        logic                     is_adc;
    } owt_frame_t;

endpackage

`default_nettype wire

//--- design/owt_err_pkg.sv
`default_nettype none

`include "owt_rx_macros.svh"

package owt_err_pkg;

    // mode 0: error while count >= add step
    // mode 1: error while count is zero
    typedef struct packed {
        logic       mode;
        logic [1:0] add_sel;
        logic [1:0] sub_sel;
    } owt_err_cfg_t;

    // step added on a bad frame
    localparam logic [`OWT_ERR_CNT_W-1:0] OWT_ERR_ADD [0:3] = '{
        5'd1, 5'd2, 5'd4, 5'd8
    };

    // step taken off on a good frame
    localparam logic [`OWT_ERR_CNT_W-1:0] OWT_ERR_SUB [0:3] = '{
        5'd1, 5'd2, 5'd3, 5'd4
    };

endpackage

`default_nettype wire

//--- design/owt_rx_edge_detect.sv
`timescale 1ns/10ps
`default_nettype none

module owt_rx_edge_detect (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_line,
    output owt_frame_pkg::owt_edge_t o_edge
);

    logic sync_q1;
    logic sync_q2;
    logic line_prev;

    // two-flop sync, then one more sample for the edge compare
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_q1   <= 1'b0;
            sync_q2   <= 1'b0;
            line_prev <= 1'b0;
            o_edge    <= '0;
        end else begin
            sync_q1       <= i_line;
            sync_q2       <= sync_q1;
            line_prev     <= sync_q2;
            o_edge.rise   <= sync_q2 & ~line_prev;
            o_edge.fall   <= ~sync_q2 & line_prev;
            // late copies line up with the registered symbol class
            o_edge.rise_d <= o_edge.rise;
            o_edge.fall_d <= o_edge.fall;
        end
    end

endmodule

`default_nettype wire

//--- design/owt_symbol_timer.sv
`timescale 1ns/10ps
`default_nettype none

`include "owt_rx_macros.svh"

module owt_symbol_timer (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  owt_frame_pkg::owt_edge_t   i_edge,
    input  owt_frame_pkg::owt_state_e  i_state,
    input  logic [`OWT_BITCNT_W-1:0]   i_bit_cnt,
    output owt_frame_pkg::owt_sym_t    o_sym
);

    import owt_frame_pkg::*;

    localparam int CW = `OWT_CYC_W;
    localparam int TW = `OWT_CYC_W + 2;

    logic          active;
    logic          edge_any;
    logic          vld;
    logic [CW-1:0] cyc_cnt;
    logic [CW-1:0] avg;
    logic [CW:0]   sum;
    logic [TW-1:0] half_up;
    logic [TW-1:0] one_up;
    logic [TW-1:0] two_up;

    assign edge_any = i_edge.rise | i_edge.fall;
    assign vld      = active & edge_any;

    // timing starts at the first head rise seen outside idle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active <= 1'b0;
        end else if (i_state == IDLE) begin
            active <= 1'b0;
        end else if (i_edge.rise) begin
            active <= 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cyc_cnt <= CW'(1);
        end else if (edge_any || !active) begin
            cyc_cnt <= CW'(1);
        end else if (cyc_cnt != '1) begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    // ======================================================================
    // symbol length learnt from the head
    // ======================================================================
    assign sum = {1'b0, cyc_cnt} + {1'b0, avg};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            avg <= '0;
        end else if (i_state == IDLE) begin
            avg <= '0;
        end else if (i_state == SYNC_HEAD && vld) begin
            if (i_bit_cnt == `OWT_BITCNT_W'(1)) begin
                avg <= cyc_cnt;
            end else if (i_bit_cnt > `OWT_BITCNT_W'(1) &&
                         i_bit_cnt < `OWT_BITCNT_W'(`OWT_AVG_LAST)) begin
                avg <= sum[CW:1];
            end
        end
    end

    // limits at 1.5 and 2.5 symbols
    assign half_up = (TW'(avg) + 1'b1) >> 1;
    assign one_up  = TW'(avg) + half_up;
    assign two_up  = one_up + TW'(avg);

    assign o_sym.vld   = vld;
    assign o_sym.one   = vld & (TW'(cyc_cnt) <= one_up);
    assign o_sym.two   = vld & (TW'(cyc_cnt) > one_up) & (TW'(cyc_cnt) <= two_up);
    assign o_sym.three = vld & (TW'(cyc_cnt) > two_up);

endmodule

`default_nettype wire

//--- design/owt_mcst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module owt_mcst_decoder (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  owt_frame_pkg::owt_edge_t  i_edge,
    input  owt_frame_pkg::owt_sym_t   i_sym,
    input  owt_frame_pkg::owt_state_e i_state,
    input  logic                      i_first_bit,
    output owt_frame_pkg::owt_bit_t   o_bit
);

    import owt_frame_pkg::*;

    localparam logic WAIT_BIT = 1'b0;
    localparam logic GEN_BIT  = 1'b1;

    owt_sym_t sym_d;
    logic     phase;
    logic     in_field;
    logic     bit_one;
    logic     bit_zero;
    logic     bad;

    assign in_field = i_state inside {CMD, ADC_DATA, NML_DATA, CRC};

    // align the class with the delayed edge strobes
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sym_d <= '0;
        end else begin
            sym_d <= i_sym;
        end
    end

    // wait: at a bit boundary, gen: at mid-bit
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase <= WAIT_BIT;
        end else if (!in_field) begin
            phase <= WAIT_BIT;
        end else if (sym_d.vld) begin
            if (sym_d.one) begin
                phase <= ~phase;
            end else if (sym_d.three) begin
                phase <= GEN_BIT;
            end else if (i_first_bit) begin
                phase <= WAIT_BIT;
            end
        end
    end

    // mid-bit fall is a one, mid-bit rise is a zero
    assign bit_one  = i_edge.fall_d &
                      ((sym_d.one & (phase == WAIT_BIT)) | (sym_d.two & (phase == GEN_BIT)));
    assign bit_zero = i_edge.rise_d &
                      ((sym_d.one & (phase == WAIT_BIT)) | (sym_d.two & (phase == GEN_BIT)) |
                       (sym_d.three & i_first_bit));

    // the only long gap allowed is the one before the first command bit
    assign bad = (sym_d.three & i_edge.fall_d) |
                 (~i_first_bit & (sym_d.three | (sym_d.two & (phase == WAIT_BIT))));

    assign o_bit.vld   = in_field & (bit_one | bit_zero);
    assign o_bit.val   = bit_one;
    assign o_bit.invld = in_field & bad;

endmodule

`default_nettype wire

//--- design/owt_crc8_serial.sv
`timescale 1ns/10ps
`default_nettype none

`include "owt_rx_macros.svh"

module owt_crc8_serial (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_start,
    input  logic                     i_vld,
    input  logic                     i_bit,
    output logic [`OWT_CRC_BITS-1:0] o_crc
);

    localparam int N = `OWT_CRC_BITS;

    logic [N-1:0] crc_base;
    logic         fb;

    // a start bit is folded into a fresh zero register
    assign crc_base = i_start ? '0 : o_crc;
    assign fb       = crc_base[N-1] ^ i_bit;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_crc <= '0;
        end else if (i_vld) begin
            o_crc <= {crc_base[N-2:0], 1'b0} ^ ({N{fb}} & `OWT_CRC_POLY);
        end
    end

endmodule

`default_nettype wire

//--- design/owt_frame_fsm.sv
`timescale 1ns/10ps
`default_nettype none

`include "owt_rx_macros.svh"

module owt_frame_fsm (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  owt_frame_pkg::owt_edge_t  i_edge,
    input  owt_frame_pkg::owt_bit_t   i_bit,
    input  logic [`OWT_CRC_BITS-1:0]  i_crc,
    output owt_frame_pkg::owt_state_e o_state,
    output logic [`OWT_BITCNT_W-1:0]  o_bit_cnt,
    output logic                      o_first_bit,
    output logic                      o_crc_start,
    output logic                      o_crc_vld,
    output logic                      o_crc_bit,
    output owt_frame_pkg::owt_frame_t o_frame,
    output logic                      o_rx_ack,
    output logic                      o_rx_status
);

    import owt_frame_pkg::*;

    localparam int BW = `OWT_BITCNT_W;

    owt_state_e               state;
    owt_state_e               state_nxt;
    logic [BW-1:0]            bit_cnt;
    logic [BW-1:0]            last_cnt;
    logic                     cnt_evt;
    logic                     last_hit;
    logic                     done_q;
    logic [`OWT_CMD_BITS-1:0] cmd_q;
    logic [`OWT_ADCD_BITS-1:0] data_q;
    logic [`OWT_CRC_BITS-1:0] crc_rx_q;
    logic                     is_adc;
    logic                     ack_c;
    logic                     status_c;

    // ======================================================================
    // counting events and field lengths
    // ======================================================================
    always_comb begin
        cnt_evt  = 1'b0;
        last_cnt = '0;
        case (state)
            SYNC_HEAD: begin
                // first head rise was taken in idle, the tail rise ends it
                cnt_evt  = i_edge.rise_d;
                last_cnt = BW'(`OWT_SYNC_BITS - 1);
            end
            SYNC_TAIL, END_TAIL: begin
                cnt_evt = i_edge.fall_d;
            end
            CMD: begin
                cnt_evt  = i_bit.vld;
                last_cnt = BW'(`OWT_CMD_BITS - 1);
            end
            ADC_DATA: begin
                cnt_evt  = i_bit.vld;
                last_cnt = BW'(`OWT_ADCD_BITS - 1);
            end
            NML_DATA: begin
                cnt_evt  = i_bit.vld;
                last_cnt = BW'(`OWT_DATA_BITS - 1);
            end
            CRC: begin
                cnt_evt  = i_bit.vld;
                last_cnt = BW'(`OWT_CRC_BITS - 1);
            end
            default: begin
                cnt_evt = 1'b0;
            end
        endcase
    end

    assign last_hit = cnt_evt & (bit_cnt == last_cnt);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bit_cnt <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= last_hit;
            if (state == IDLE || i_bit.invld) begin
                bit_cnt <= '0;
            end else if (cnt_evt) begin
                bit_cnt <= last_hit ? '0 : bit_cnt + 1'b1;
            end
        end
    end

    // read of the adc address, msb low means read
    assign is_adc = ~cmd_q[`OWT_CMD_BITS-1] & (cmd_q[`OWT_CMD_BITS-2:0] == `OWT_ADC_ADDR);

    // ======================================================================
    // frame state machine
    // ======================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (i_edge.rise_d) begin
                    state_nxt = SYNC_HEAD;
                end
            end
            SYNC_HEAD: begin
                if (done_q) begin
                    state_nxt = SYNC_TAIL;
                end
            end
            SYNC_TAIL: begin
                if (done_q) begin
                    state_nxt = CMD;
                end
            end
            CMD: begin
                if (i_bit.invld) begin
                    state_nxt = IDLE;
                end else if (done_q) begin
                    state_nxt = is_adc ? ADC_DATA : NML_DATA;
                end
            end
            ADC_DATA, NML_DATA: begin
                if (i_bit.invld) begin
                    state_nxt = IDLE;
                end else if (done_q) begin
                    state_nxt = CRC;
                end
            end
            CRC: begin
                if (i_bit.invld) begin
                    state_nxt = IDLE;
                end else if (done_q) begin
                    state_nxt = END_TAIL;
                end
            end
            END_TAIL: begin
                if (done_q) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // field shift registers, msb first
    always_ff @(posedge i_clk) begin
        if (i_bit.vld) begin
            case (state)
                CMD: begin
                    cmd_q <= {cmd_q[`OWT_CMD_BITS-2:0], i_bit.val};
                    if (o_first_bit) begin
                        data_q <= '0;
                    end
                end
                ADC_DATA, NML_DATA: begin
                    data_q <= {data_q[`OWT_ADCD_BITS-2:0], i_bit.val};
                end
                CRC: begin
                    crc_rx_q <= {crc_rx_q[`OWT_CRC_BITS-2:0], i_bit.val};
                end
                default: begin
                    cmd_q <= cmd_q;
                end
            endcase
        end
    end

    assign o_first_bit = (state == CMD) & (bit_cnt == '0);
    assign o_crc_start = i_bit.vld & o_first_bit;
    assign o_crc_vld   = i_bit.vld & (state inside {CMD, ADC_DATA, NML_DATA});
    assign o_crc_bit   = i_bit.val;

    // ======================================================================
    // acknowledge on every return to idle
    // ======================================================================
    assign ack_c    = (state != IDLE) & (state_nxt == IDLE);
    assign status_c = (state != END_TAIL) | (crc_rx_q != i_crc);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rx_ack    <= 1'b0;
            o_rx_status <= 1'b0;
        end else begin
            o_rx_ack <= ack_c;
            if (ack_c) begin
                o_rx_status <= status_c;
            end
        end
    end

    assign o_state         = state;
    assign o_bit_cnt       = bit_cnt;
    assign o_frame.cmd     = cmd_q;
    assign o_frame.data    = data_q;
    assign o_frame.is_adc  = is_adc;

    // frame parts only move forward, or drop back to idle
    a_state_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state_nxt != state) |-> ((state_nxt == IDLE) || (state_nxt > state)));

    a_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rx_ack |=> !o_rx_ack);

endmodule

`default_nettype wire

//--- design/owt_com_err_monitor.sv
`timescale 1ns/10ps
`default_nettype none

`include "owt_rx_macros.svh"

module owt_com_err_monitor (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  owt_err_pkg::owt_err_cfg_t i_cfg,
    input  logic                      i_rx_ack,
    input  logic                      i_rx_status,
    output logic                      o_com_err
);

    import owt_err_pkg::*;

    localparam int W = `OWT_ERR_CNT_W;

    logic [W-1:0] cnt;
    logic [W-1:0] cnt_nxt;
    logic [W-1:0] add_step;
    logic [W-1:0] sub_step;
    logic [W:0]   sum;

    assign add_step = OWT_ERR_ADD[i_cfg.add_sel];
    assign sub_step = OWT_ERR_SUB[i_cfg.sub_sel];
    assign sum      = {1'b0, cnt} + {1'b0, add_step};

    // bad frames fill the bucket, good ones drain it
    always_comb begin
        cnt_nxt = cnt;
        if (i_rx_ack) begin
            if (i_rx_status) begin
                cnt_nxt = (sum >= (W+1)'(`OWT_ERR_MAX)) ? W'(`OWT_ERR_MAX) : sum[W-1:0];
            end else begin
                cnt_nxt = (sub_step >= cnt) ? '0 : cnt - sub_step;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt       <= W'(`OWT_ERR_INIT);
            o_com_err <= 1'b1;
        end else begin
            cnt <= cnt_nxt;
            // level follows the new count in the same cycle
            o_com_err <= i_cfg.mode ? (cnt_nxt == '0) : (cnt_nxt >= add_step);
        end
    end

    a_cnt_ceiling: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        cnt <= W'(`OWT_ERR_MAX));

endmodule

`default_nettype wire

//--- design/owt_rx_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "owt_rx_macros.svh"

module owt_rx_top (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_line,
    input  owt_err_pkg::owt_err_cfg_t i_cfg,
    output owt_frame_pkg::owt_frame_t o_frame,
    output logic                      o_rx_ack,
    output logic                      o_rx_status,
    output logic                      o_com_err
);

    import owt_frame_pkg::*;

    owt_edge_t                line_edge;
    owt_sym_t                 sym;
    owt_bit_t                 mcst_bit;
    owt_state_e               state;
    logic [`OWT_BITCNT_W-1:0] bit_cnt;
    logic                     first_bit;
    logic                     crc_start;
    logic                     crc_vld;
    logic                     crc_bit;
    logic [`OWT_CRC_BITS-1:0] crc;

    owt_rx_edge_detect owt_rx_edge_detect_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_line  (i_line),
        .o_edge  (line_edge)
    );

    owt_symbol_timer owt_symbol_timer_inst (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_edge    (line_edge),
        .i_state   (state),
        .i_bit_cnt (bit_cnt),
        .o_sym     (sym)
    );

    owt_mcst_decoder owt_mcst_decoder_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_edge      (line_edge),
        .i_sym       (sym),
        .i_state     (state),
        .i_first_bit (first_bit),
        .o_bit       (mcst_bit)
    );

    owt_frame_fsm owt_frame_fsm_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_edge      (line_edge),
        .i_bit       (mcst_bit),
        .i_crc       (crc),
        .o_state     (state),
        .o_bit_cnt   (bit_cnt),
        .o_first_bit (first_bit),
        .o_crc_start (crc_start),
        .o_crc_vld   (crc_vld),
        .o_crc_bit   (crc_bit),
        .o_frame     (o_frame),
        .o_rx_ack    (o_rx_ack),
        .o_rx_status (o_rx_status)
    );

    owt_crc8_serial owt_crc8_serial_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (crc_start),
        .i_vld   (crc_vld),
        .i_bit   (crc_bit),
        .o_crc   (crc)
    );

    owt_com_err_monitor owt_com_err_monitor_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cfg       (i_cfg),
        .i_rx_ack    (o_rx_ack),
        .i_rx_status (o_rx_status),
        .o_com_err   (o_com_err)
    );

endmodule

`default_nettype wire

//--- tb/tb_owt_rx_model.svh
`ifndef TB_OWT_RX_MODEL_SVH
`define TB_OWT_RX_MODEL_SVH

// ==========================================================================
// line encoder
// ==========================================================================

// hold one level, entered just after a rising edge
task automatic hold_line(input logic lvl, input int cycles);
    int k;
    line = lvl;
    for (k = 0; k < cycles; k++) begin
        @(posedge clk);
        #STIM_DLY;
    end
endtask

// square head pulses, then the double-length tail
task automatic send_head();
    int k;
    for (k = 0; k < `OWT_SYNC_BITS; k++) begin
        hold_line(1'b1, sym_len);
        hold_line(1'b0, sym_len);
    end
    hold_line(1'b1, 2 * sym_len);
    hold_line(1'b0, 2 * sym_len);
endtask

// msb first; a one falls mid-bit, a zero rises mid-bit
task automatic send_bits(input logic [19:0] value, input int n);
    int k;
    for (k = n - 1; k >= 0; k--) begin
        hold_line(value[k], sym_len);
        hold_line(~value[k], sym_len);
    end
endtask

task automatic send_end_tail();
    hold_line(1'b1, 2 * sym_len);
endtask

// three-symbol low inside a field, closed by a short high
task automatic inject_long_low();
    hold_line(1'b0, 3 * sym_len);
    hold_line(1'b1, sym_len);
endtask

// ==========================================================================
// reference models
// ==========================================================================

// crc-8 over the n low bits of bits, msb first, zero start
function automatic logic [7:0] crc8_ref(input logic [19:0] bits, input int n);
    logic [7:0] r;
    logic       top;
    int         k;
    r = 8'h00;
    for (k = n - 1; k >= 0; k--) begin
        top = r[7] ^ bits[k];
        r   = {r[6:0], 1'b0};
        if (top) begin
            r = r ^ `OWT_CRC_POLY;
        end
    end
    return r;
endfunction

// leaky bucket, saturating up and floored at zero
function automatic int err_next(input int cnt, input logic bad, input owt_err_cfg_t c);
    int n;
    if (bad) begin
        n = cnt + int'(OWT_ERR_ADD[c.add_sel]);
        if (n > `OWT_ERR_MAX) begin
            n = `OWT_ERR_MAX;
        end
    end else begin
        n = cnt - int'(OWT_ERR_SUB[c.sub_sel]);
        if (n < 0) begin
            n = 0;
        end
    end
    return n;
endfunction

function automatic logic err_level(input int cnt, input owt_err_cfg_t c);
    if (c.mode) begin
        return (cnt == 0);
    end
    return (cnt >= int'(OWT_ERR_ADD[c.add_sel]));
endfunction

`endif

//--- tb/tb_owt_rx.sv
`timescale 1ns/10ps
`default_nettype none

`include "owt_rx_macros.svh"

module tb_owt_rx;

    import owt_frame_pkg::*;
    import owt_err_pkg::*;

    localparam int CLK_HALF    = 20;
    localparam int STIM_DLY    = 2;
    localparam int RST_CYCLES  = 8;
    localparam int ACK_TIMEOUT = 400;
    localparam int SEED        = 95908;

    // frame kinds
    localparam int K_WRITE   = 0;
    localparam int K_ADC     = 1;
    localparam int K_BAD_CRC = 2;
    localparam int K_ABORT   = 3;

    logic         clk;
    logic         rst_n;
    logic         line;
    owt_err_cfg_t cfg;
    owt_frame_t   frame;
    logic         rx_ack;
    logic         rx_status;
    logic         com_err;

    int           sym_len;
    int           errors;
    int           checks;
    int           ack_cnt;
    int           acks_expected;
    int           model_cnt;
    logic         stall;
    logic         ack_status;
    owt_frame_t   ack_frame;

    `include "tb_owt_rx_model.svh"

    owt_rx_top owt_rx_top_inst (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_line      (line),
        .i_cfg       (cfg),
        .o_frame     (frame),
        .o_rx_ack    (rx_ack),
        .o_rx_status (rx_status),
        .o_com_err   (com_err)
    );

    always #(CLK_HALF) clk = ~clk;

    // record each acknowledge half a cycle after it rises
    always @(negedge clk) begin
        if (rst_n && rx_ack) begin
            ack_cnt    = ack_cnt + 1;
            ack_status = rx_status;
            ack_frame  = frame;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got=0x%0h exp=0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic wait_ack(input int want);
        int waited;
        waited = 0;
        while (ack_cnt < want && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (ack_cnt < want) begin
            $display("receiver stalled: no acknowledge within %0d cycles of the frame end",
                     ACK_TIMEOUT);
            errors++;
            stall = 1'b1;
        end
    endtask

    task automatic pick_config();
        @(posedge clk);
        #STIM_DLY;
        cfg = 5'($urandom);
    endtask

    // ======================================================================
    // one frame: encode, wait for the ack, compare with the models
    // ======================================================================
    task automatic run_frame(input int kind);
        logic [7:0]  cmd;
        logic [11:0] data;
        logic [7:0]  crc;
        logic        bad;
        int          nd;
        int          cut;
        sym_len = 8 + ($urandom % 13);
        if (kind == K_ADC) begin
            cmd = 8'h1F;
            nd  = 12;
        end else begin
            cmd = {1'b1, 7'($urandom)};
            nd  = 8;
        end
        data = 12'($urandom);
        if (nd == 8) begin
            data[11:8] = 4'h0;
        end
        crc = crc8_ref((20'(cmd) << nd) | 20'(data), 8 + nd);
        if (kind == K_BAD_CRC) begin
            crc = crc ^ 8'(1 + ($urandom % 255));
        end
        cut = 1 + ($urandom % 4);
        bad = (kind == K_BAD_CRC) || (kind == K_ABORT);

        @(posedge clk);
        #STIM_DLY;
        send_head();
        send_bits(20'(cmd), 8);
        if (kind == K_ABORT) begin
            // a few data bits, then the long low
            send_bits(20'(data >> (nd - cut)), cut);
            inject_long_low();
        end else begin
            send_bits(20'(data), nd);
            send_bits(20'(crc), 8);
            send_end_tail();
        end
        hold_line(1'b0, 3 * sym_len);

        acks_expected++;
        wait_ack(acks_expected);
        if (!stall) begin
            model_cnt = err_next(model_cnt, bad, cfg);
            @(negedge clk);
            check_val("ack_count", ack_cnt, acks_expected);
            check_val("o_rx_status", ack_status, bad);
            if (kind != K_ABORT) begin
                check_val("o_frame.cmd", ack_frame.cmd, cmd);
                check_val("o_frame.is_adc", ack_frame.is_adc, kind == K_ADC);
                if (kind == K_ADC) begin
                    check_val("o_frame.data.adc", ack_frame.data.adc, data);
                end else begin
                    check_val("o_frame.data.nml.value", ack_frame.data.nml.value, data[7:0]);
                end
            end
            check_val("o_com_err", com_err, err_level(model_cnt, cfg));
        end
    endtask

    initial begin
        int i;
        clk           = 1'b0;
        rst_n         = 1'b0;
        line          = 1'b0;
        cfg           = '0;
        sym_len       = 8;
        errors        = 0;
        checks        = 0;
        ack_cnt       = 0;
        acks_expected = 0;
        model_cnt     = `OWT_ERR_INIT;
        stall         = 1'b0;
        ack_status    = 1'b0;
        ack_frame     = '0;
        void'($urandom(SEED));

        repeat (RST_CYCLES) @(posedge clk);
        #STIM_DLY;
        rst_n = 1'b1;

        // reset values
        @(negedge clk);
        check_val("o_rx_ack", rx_ack, 1'b0);
        check_val("o_rx_status", rx_status, 1'b0);
        check_val("o_com_err", com_err, 1'b1);

        for (i = 0; i < 10; i++) begin
            if (!stall) begin
                run_frame(K_WRITE);
            end
        end

        for (i = 0; i < 4; i++) begin
            if (!stall) begin
                run_frame(K_ADC);
            end
        end

        // corrupted crc and aborted fields
        for (i = 0; i < 6; i++) begin
            if (!stall) begin
                run_frame((i % 2 == 0) ? K_BAD_CRC : K_ABORT);
            end
        end

        // random config with a random mix of frames
        for (i = 0; i < 40; i++) begin
            if (!stall) begin
                pick_config();
                run_frame($urandom % 4);
            end
        end

        if (!stall) begin
            // no stray acknowledge while the line stays idle
            repeat (ACK_TIMEOUT) @(posedge clk);
            @(negedge clk);
            check_val("ack_count", ack_cnt, acks_expected);
        end

        $display("frames=%0d acks=%0d checks=%0d errors=%0d",
                 acks_expected, ack_cnt, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- owt_rx_top.f
+incdir+design
+incdir+tb
design/owt_frame_pkg.sv
design/owt_err_pkg.sv
design/owt_rx_edge_detect.sv
design/owt_symbol_timer.sv
design/owt_mcst_decoder.sv
design/owt_crc8_serial.sv
design/owt_frame_fsm.sv
design/owt_com_err_monitor.sv
design/owt_rx_top.sv
tb/tb_owt_rx.sv

//--- Makefile
# Verilator build and run for the one-wire receiver testbench

VERILATOR ?= verilator
TOP       ?= tb_owt_rx
FILELIST  ?= owt_rx_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
PASS_MSG  ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# fails unless the pass line shows up in the output
run: compile
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
